// ==== design/mc_defs.svh ====
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// word address and data widths
`define MC_ADDR_WIDTH 10
`define MC_DATA_WIDTH 32

// mesh coordinates
`define MC_X_CORD_WIDTH 4
`define MC_Y_CORD_WIDTH 4

// link buffering and flow control
`define MC_FIFO_DEPTH 4
`define MC_MAX_CREDITS 4

// host sits at the origin
`define MC_HOST_X 0
`define MC_HOST_Y 0

`define MC_TILE_X 1
`define MC_TILE_Y 1

// top word address is reserved for finish
`define MC_FINISH_ADDR ((1 << `MC_ADDR_WIDTH) - 1)

`endif

// ==== design/mc_link_pkg.sv ====
`default_nettype none

`include "mc_defs.svh"

package mc_link_pkg;

  typedef enum logic [0:0] {
    MC_OP_STORE = 1'b0,
    MC_OP_LOAD  = 1'b1
  } mc_op_e;

  // request packet, 59 bits
  typedef struct packed {
    mc_op_e                      op;
    logic [`MC_X_CORD_WIDTH-1:0] dst_x;
    logic [`MC_Y_CORD_WIDTH-1:0] dst_y;
    logic [`MC_X_CORD_WIDTH-1:0] src_x; // return path for loads
    logic [`MC_Y_CORD_WIDTH-1:0] src_y;
    logic [`MC_ADDR_WIDTH-1:0]   addr;
    logic [`MC_DATA_WIDTH-1:0]   data;
  } mc_req_s;

  typedef struct packed {
    logic [`MC_X_CORD_WIDTH-1:0] dst_x;
    logic [`MC_Y_CORD_WIDTH-1:0] dst_y;
    logic [`MC_ADDR_WIDTH-1:0]   addr;
    logic [`MC_DATA_WIDTH-1:0]   data;
    logic                        err; // set on misrouted load
  } mc_rsp_s;

endpackage

`default_nettype wire

// ==== design/mc_host_pkg.sv ====
`default_nettype none

`include "mc_defs.svh"

package mc_host_pkg;

  // host command, source coords get stamped by the io complex
  typedef struct packed {
    mc_link_pkg::mc_op_e         op;
    logic [`MC_X_CORD_WIDTH-1:0] dst_x;
    logic [`MC_Y_CORD_WIDTH-1:0] dst_y;
    logic [`MC_ADDR_WIDTH-1:0]   addr;
    logic [`MC_DATA_WIDTH-1:0]   data;
  } host_cmd_s;

  // load response as the host sees it
  typedef struct packed {
    logic [`MC_ADDR_WIDTH-1:0] addr;
    logic [`MC_DATA_WIDTH-1:0] data;
    logic                      err;
  } host_rsp_s;

endpackage

`default_nettype wire

// ==== design/mc_link_fifo.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_link_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned depth_p   = `MC_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     wr_en_i,
  input  payload_t data_i,
  input  logic     rd_en_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int unsigned cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem_q [depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    push;
  logic                    pop;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(depth_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == cnt_width_lp'(depth_p));
  assign empty_o = (count_q == '0);
  assign push    = wr_en_i & ~full_o;
  assign pop     = rd_en_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q]; // fall-through head

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

// ==== design/mc_io_complex.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_io_complex (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   cmd_v_i,
  input  mc_host_pkg::host_cmd_s cmd_i,
  output logic                   busy_o,
  output logic                   rsp_v_o,
  output mc_host_pkg::host_rsp_s rsp_o,
  output logic                   req_wr_o,
  output mc_link_pkg::mc_req_s   req_o,
  input  logic                   req_full_i,
  output logic                   rsp_rd_o,
  input  mc_link_pkg::mc_rsp_s   rsp_i,
  input  logic                   rsp_empty_i
);

  import mc_host_pkg::*;
  import mc_link_pkg::*;

  localparam int unsigned                 credit_width_lp = $clog2(`MC_MAX_CREDITS + 1);
  localparam logic [`MC_X_CORD_WIDTH-1:0] host_x_lp       = `MC_HOST_X;
  localparam logic [`MC_Y_CORD_WIDTH-1:0] host_y_lp       = `MC_HOST_Y;

  logic                       accept;
  logic                       load_accept;
  logic [credit_width_lp-1:0] credits_q;
  mc_req_s                    req_d;
  mc_req_s                    req_q;
  logic                       req_v_q;
  logic                       rsp_v_q;
  host_rsp_s                  rsp_q;

  // no look at the command itself, stores also wait on credits
  assign busy_o      = req_full_i | (credits_q == '0);
  assign accept      = cmd_v_i & ~busy_o;
  assign load_accept = accept & (cmd_i.op == MC_OP_LOAD);

  always_comb begin
    req_d.op    = cmd_i.op;
    req_d.dst_x = cmd_i.dst_x;
    req_d.dst_y = cmd_i.dst_y;
    req_d.src_x = host_x_lp;
    req_d.src_y = host_y_lp;
    req_d.addr  = cmd_i.addr;
    req_d.data  = cmd_i.data;
  end

  // held while the link FIFO is full, busy_o keeps the host off meanwhile
  assign req_wr_o = req_v_q & ~req_full_i;
  assign req_o    = req_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      req_v_q <= 1'b0;
    else if (accept)
      req_v_q <= 1'b1;
    else if (req_wr_o)
      req_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (accept)
      req_q <= req_d;
  end

  // one credit per outstanding load
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      credits_q <= credit_width_lp'(`MC_MAX_CREDITS);
    else
      credits_q <= credits_q - credit_width_lp'(load_accept) + credit_width_lp'(rsp_rd_o);
  end

  // drain responses as soon as they show up
  assign rsp_rd_o = ~rsp_empty_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      rsp_v_q <= 1'b0;
    else
      rsp_v_q <= rsp_rd_o;
  end

  always_ff @(posedge clk_i) begin
    if (rsp_rd_o) begin
      rsp_q.addr <= rsp_i.addr;
      rsp_q.data <= rsp_i.data;
      rsp_q.err  <= rsp_i.err;
    end
  end

  assign rsp_v_o = rsp_v_q;
  assign rsp_o   = rsp_q;

endmodule

`default_nettype wire

// ==== design/mc_tile_endpoint.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_tile_endpoint #(
  parameter logic [`MC_X_CORD_WIDTH-1:0] tile_x_p = `MC_TILE_X,
  parameter logic [`MC_Y_CORD_WIDTH-1:0] tile_y_p = `MC_TILE_Y
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mc_link_pkg::mc_req_s       req_i,
  input  logic                       req_empty_i,
  output logic                       req_rd_o,
  input  logic                       rsp_full_i,
  output logic                       rsp_wr_o,
  output mc_link_pkg::mc_rsp_s       rsp_o,
  output logic                       finish_v_o,
  output logic [`MC_DATA_WIDTH-1:0]  finish_tag_o
);

  import mc_link_pkg::*;

  localparam int unsigned mem_words_lp = 1 << `MC_ADDR_WIDTH;

  logic [`MC_DATA_WIDTH-1:0]   mem_q [mem_words_lp];
  logic                        pop;
  logic                        hit;
  logic                        is_finish;
  logic                        store_pop;
  logic                        load_pop;
  logic                        mem_we;
  logic                        finish_set;
  logic [`MC_DATA_WIDTH-1:0]   rd_data_q;
  logic                        rsp_wr_q;
  logic [`MC_X_CORD_WIDTH-1:0] rsp_dst_x_q;
  logic [`MC_Y_CORD_WIDTH-1:0] rsp_dst_y_q;
  logic [`MC_ADDR_WIDTH-1:0]   rsp_addr_q;
  logic                        rsp_err_q;
  logic                        finish_v_q;
  logic [`MC_DATA_WIDTH-1:0]   finish_tag_q;

  // credits bound the loads in flight, so one pending response never overflows
  assign req_rd_o = ~req_empty_i & ~rsp_full_i;
  assign pop      = req_rd_o;

  assign hit       = (req_i.dst_x == tile_x_p) && (req_i.dst_y == tile_y_p);
  assign is_finish = (req_i.addr == `MC_ADDR_WIDTH'(`MC_FINISH_ADDR));
  assign store_pop = pop & (req_i.op == MC_OP_STORE);
  assign load_pop  = pop & (req_i.op == MC_OP_LOAD);

  // misrouted stores fall through here and are dropped
  assign mem_we     = store_pop & hit & ~is_finish;
  assign finish_set = store_pop & hit & is_finish;

  // data memory, registered read
  always_ff @(posedge clk_i) begin
    if (mem_we)
      mem_q[req_i.addr] <= req_i.data;
    if (load_pop)
      rd_data_q <= mem_q[req_i.addr];
  end

  always_ff @(posedge clk_i) begin
    if (load_pop) begin
      rsp_dst_x_q <= req_i.src_x; // back to the requester
      rsp_dst_y_q <= req_i.src_y;
      rsp_addr_q  <= req_i.addr;
      rsp_err_q   <= ~hit;
    end
    if (finish_set)
      finish_tag_q <= req_i.data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_wr_q   <= 1'b0;
      finish_v_q <= 1'b0;
    end else begin
      rsp_wr_q   <= load_pop;
      finish_v_q <= finish_set;
    end
  end

  always_comb begin
    rsp_o.dst_x = rsp_dst_x_q;
    rsp_o.dst_y = rsp_dst_y_q;
    rsp_o.addr  = rsp_addr_q;
    rsp_o.data  = rsp_err_q ? '0 : rd_data_q; // error carries zero data
    rsp_o.err   = rsp_err_q;
  end

  assign rsp_wr_o     = rsp_wr_q;
  assign finish_v_o   = finish_v_q;
  assign finish_tag_o = finish_tag_q;

endmodule

`default_nettype wire

// ==== design/mc_spmd_top.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_spmd_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cmd_v_i,
  input  mc_host_pkg::host_cmd_s    cmd_i,
  output logic                      busy_o,
  output logic                      rsp_v_o,
  output mc_host_pkg::host_rsp_s    rsp_o,
  output logic                      finish_v_o,
  output logic [`MC_DATA_WIDTH-1:0] finish_tag_o
);

  import mc_link_pkg::*;

  // request path
  logic    req_wr;
  mc_req_s req_pkt;
  logic    req_full;
  logic    req_rd;
  mc_req_s req_head;
  logic    req_empty;

  // response path
  logic    rsp_wr;
  mc_rsp_s rsp_pkt;
  logic    rsp_full;
  logic    rsp_rd;
  mc_rsp_s rsp_head;
  logic    rsp_empty;

  mc_io_complex i_io_complex (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_i       (cmd_i),
    .busy_o      (busy_o),
    .rsp_v_o     (rsp_v_o),
    .rsp_o       (rsp_o),
    .req_wr_o    (req_wr),
    .req_o       (req_pkt),
    .req_full_i  (req_full),
    .rsp_rd_o    (rsp_rd),
    .rsp_i       (rsp_head),
    .rsp_empty_i (rsp_empty)
  );

  mc_link_fifo #(
    .payload_t (mc_req_s),
    .depth_p   (`MC_FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wr_en_i  (req_wr),
    .data_i   (req_pkt),
    .rd_en_i  (req_rd),
    .data_o   (req_head),
    .full_o   (req_full),
    .empty_o  (req_empty)
  );

  mc_tile_endpoint #(
    .tile_x_p (`MC_X_CORD_WIDTH'(`MC_TILE_X)),
    .tile_y_p (`MC_Y_CORD_WIDTH'(`MC_TILE_Y))
  ) i_tile (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req_head),
    .req_empty_i  (req_empty),
    .req_rd_o     (req_rd),
    .rsp_full_i   (rsp_full),
    .rsp_wr_o     (rsp_wr),
    .rsp_o        (rsp_pkt),
    .finish_v_o   (finish_v_o),
    .finish_tag_o (finish_tag_o)
  );

  mc_link_fifo #(
    .payload_t (mc_rsp_s),
    .depth_p   (`MC_FIFO_DEPTH)
  ) i_rsp_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wr_en_i  (rsp_wr),
    .data_i   (rsp_pkt),
    .rd_en_i  (rsp_rd),
    .data_o   (rsp_head),
    .full_o   (rsp_full),
    .empty_o  (rsp_empty)
  );

endmodule

`default_nettype wire

// ==== test/mc_spmd_checker.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_spmd_checker #(
  parameter int unsigned credit_width_p = $clog2(`MC_MAX_CREDITS + 1)
) (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      cmd_v_i,
  input logic                      busy_i,
  input logic                      rsp_v_i,
  input logic                      finish_v_i,
  input logic [credit_width_p-1:0] credits_i,
  input logic                      rsp_wr_i,
  input logic                      rsp_full_i
);

  localparam logic [credit_width_p-1:0] max_credits_lp = `MC_MAX_CREDITS;

  // host has to hold off while busy
  cmd_not_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i |-> !busy_i)
    else $error("command strobe while busy_o is high");

  finish_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    finish_v_i |=> !finish_v_i)
    else $error("finish_v_o held longer than one cycle");

  // the pop one cycle earlier needs a load in flight
  rsp_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_v_i |-> $past(credits_i) != max_credits_lp)
    else $error("rsp_v_o with all credits returned");

  rsp_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rsp_wr_i && rsp_full_i))
    else $error("response FIFO written while full");

endmodule

bind mc_spmd_top mc_spmd_checker i_checker (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .cmd_v_i    (cmd_v_i),
  .busy_i     (busy_o),
  .rsp_v_i    (rsp_v_o),
  .finish_v_i (finish_v_o),
  .credits_i  (i_io_complex.credits_q),
  .rsp_wr_i   (rsp_wr),
  .rsp_full_i (rsp_full)
);

`default_nettype wire

// ==== test/tb_mc_spmd.sv ====
`default_nettype none

`include "mc_defs.svh"

module tb_mc_spmd;

  import mc_host_pkg::*;
  import mc_link_pkg::*;

  // reset 0, store_load 2, burst 16, misroute 4, finish 1, random 64
  localparam int unsigned n_cmds_lp         = 87;
  localparam int unsigned timeout_cycles_lp = n_cmds_lp * 40 + 500;
  localparam int unsigned burst_len_lp      = 8;

  logic                      clk;
  logic                      arst_n;
  logic                      cmd_v;
  host_cmd_s                 cmd;
  logic                      busy;
  logic                      rsp_v;
  host_rsp_s                 rsp;
  logic                      finish_v;
  logic [`MC_DATA_WIDTH-1:0] finish_tag;

  host_rsp_s                 exp_q [$]; // expected load responses in order
  logic [`MC_DATA_WIDTH-1:0] ref_mem [int];
  int unsigned               finish_cnt;
  logic [`MC_DATA_WIDTH-1:0] finish_tag_seen;
  integer                    seed;

  mc_spmd_top i_mc_spmd_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .cmd_v_i      (cmd_v),
    .cmd_i        (cmd),
    .busy_o       (busy),
    .rsp_v_o      (rsp_v),
    .rsp_o        (rsp),
    .finish_v_o   (finish_v),
    .finish_tag_o (finish_tag)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_failed();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // issue one command and update the model
  task automatic send_cmd(input mc_op_e op, input int x, input int y,
                          input logic [`MC_ADDR_WIDTH-1:0] addr,
                          input logic [`MC_DATA_WIDTH-1:0] data);
    host_rsp_s exp;
    logic      hit;
    hit = (x == `MC_TILE_X) && (y == `MC_TILE_Y);
    while (busy)
      next_cycle();
    cmd_v     = 1'b1;
    cmd.op    = op;
    cmd.dst_x = x;
    cmd.dst_y = y;
    cmd.addr  = addr;
    cmd.data  = data;
    if (op == MC_OP_LOAD) begin
      exp.addr = addr;
      exp.err  = !hit;
      exp.data = hit ? ref_mem[addr] : '0;
      exp_q.push_back(exp);
    end else if (hit && addr != `MC_FINISH_ADDR) begin
      ref_mem[addr] = data;
    end
    next_cycle();
    cmd_v = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      next_cycle();
  endtask

  // sampled at the falling edge away from register updates
  always @(negedge clk) begin
    host_rsp_s exp;
    if (arst_n && rsp_v) begin
      if (exp_q.size() == 0) begin
        $display("a load response arrived with no load outstanding");
        stop_failed();
      end else begin
        exp = exp_q.pop_front();
        check_val("rsp_o.addr", rsp.addr, exp.addr);
        check_val("rsp_o.data", rsp.data, exp.data);
        check_val("rsp_o.err", rsp.err, exp.err);
      end
    end
    if (arst_n && finish_v) begin
      finish_cnt++;
      finish_tag_seen = finish_tag;
    end
  end

  task automatic test_reset();
    check_val("busy_o", busy, 1'b0);
    check_val("rsp_v_o", rsp_v, 1'b0);
    check_val("finish_v_o", finish_v, 1'b0);
  endtask

  task automatic test_store_load();
    send_cmd(MC_OP_STORE, `MC_TILE_X, `MC_TILE_Y, 10'h055, 32'hdeadbeef);
    send_cmd(MC_OP_LOAD, `MC_TILE_X, `MC_TILE_Y, 10'h055, '0);
    wait_drain();
  endtask

  task automatic test_burst();
    for (int i = 0; i < burst_len_lp; i++)
      send_cmd(MC_OP_STORE, `MC_TILE_X, `MC_TILE_Y, 10'h100 + i, $random(seed));
    for (int i = 0; i < burst_len_lp; i++)
      send_cmd(MC_OP_LOAD, `MC_TILE_X, `MC_TILE_Y, 10'h100 + i, '0); // runs into credits
    wait_drain();
  endtask

  task automatic test_misroute();
    send_cmd(MC_OP_STORE, `MC_TILE_X, `MC_TILE_Y, 10'h0a0, 32'h1234_5678);
    send_cmd(MC_OP_STORE, 2, 1, 10'h0a0, 32'hbad0_bad0); // dropped by the tile
    send_cmd(MC_OP_LOAD, `MC_TILE_X, `MC_TILE_Y, 10'h0a0, '0);
    send_cmd(MC_OP_LOAD, 3, 0, 10'h0a0, '0);
    wait_drain();
  endtask

  task automatic test_finish();
    int unsigned               start_cnt;
    logic [`MC_DATA_WIDTH-1:0] tag;
    start_cnt = finish_cnt;
    tag       = $random(seed);
    send_cmd(MC_OP_STORE, `MC_TILE_X, `MC_TILE_Y, `MC_FINISH_ADDR, tag);
    while (finish_cnt == start_cnt)
      next_cycle();
    check_val("finish_tag_o", finish_tag_seen, tag);
    repeat (8) next_cycle(); // any stray response trips the monitor
    check_val("finish count", finish_cnt, start_cnt + 1);
  endtask

  task automatic test_random();
    logic [31:0]               r;
    logic [`MC_ADDR_WIDTH-1:0] addr;
    for (int i = 0; i < 64; i++) begin
      r    = $random(seed);
      addr = r[8:3]; // small window that never reaches the finish word
      if (r[0] && ref_mem.exists(addr))
        send_cmd(MC_OP_LOAD, `MC_TILE_X, `MC_TILE_Y, addr, '0);
      else
        send_cmd(MC_OP_STORE, `MC_TILE_X, `MC_TILE_Y, addr, $random(seed));
    end
    wait_drain();
  endtask

  initial begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("timeout: the tests did not complete in %0d cycles", timeout_cycles_lp);
    stop_failed();
  end

  initial begin
    seed       = 32'hc41e;
    finish_cnt = 0;
    arst_n     = 1'b0;
    cmd_v      = 1'b0;
    cmd        = '0;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    test_reset();
    next_cycle();
    test_store_load();
    test_burst();
    test_misroute();
    test_finish();
    test_random();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/mc_link_pkg.sv
design/mc_host_pkg.sv
design/mc_link_fifo.sv
design/mc_io_complex.sv
design/mc_tile_endpoint.sv
design/mc_spmd_top.sv
test/mc_spmd_checker.sv
test/tb_mc_spmd.sv

// ==== Bender.yml ====
package:
  name: mc_spmd

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mc_link_pkg.sv
      - design/mc_host_pkg.sv
      - design/mc_link_fifo.sv
      - design/mc_io_complex.sv
      - design/mc_tile_endpoint.sv
      - design/mc_spmd_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/mc_spmd_checker.sv
      - test/tb_mc_spmd.sv
